//--- axi_mem_subsys.f
logic/axi_mem_pkg.sv
logic/axi_rd_if.sv
logic/axi_wr_if.sv
logic/axi_rd_arbiter.sv
logic/axi_sram.sv
logic/axi_mem_subsys.sv
verif/axi_mem_subsys_tb.sv

//--- logic/axi_mem_pkg.sv
package axi_mem_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // SRAM geometry, 64-bit words
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam int WORD_LSB = $clog2(STRB_W);

    // Address step between the two beats of a burst
    localparam logic [ADDR_W-1:0] BEAT_BYTES = ADDR_W'(STRB_W);

    // Response codes
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'd0;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

    // Owner of the shared read channel
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_IFU = 2'd1,
        GRANT_LSU = 2'd2
    } rd_grant_e;

endpackage

//--- logic/axi_mem_subsys.sv
`timescale 1ns/1ps

module axi_mem_subsys (
    input logic clk,
    input logic rst,

    // IFU read
    input logic ifu_ar_valid_i,
    input logic [axi_mem_pkg::ADDR_W-1:0] ifu_ar_addr_i,
    input logic ifu_ar_len_i,
    input logic ifu_r_ready_i,
    output logic ifu_ar_ready_o,
    output logic ifu_r_valid_o,
    output logic [axi_mem_pkg::RESP_W-1:0] ifu_r_resp_o,
    output logic [axi_mem_pkg::DATA_W-1:0] ifu_r_data_o,

    // LSU read
    input logic lsu_ar_valid_i,
    input logic [axi_mem_pkg::ADDR_W-1:0] lsu_ar_addr_i,
    input logic lsu_ar_len_i,
    input logic lsu_r_ready_i,
    output logic lsu_ar_ready_o,
    output logic lsu_r_valid_o,
    output logic [axi_mem_pkg::RESP_W-1:0] lsu_r_resp_o,
    output logic [axi_mem_pkg::DATA_W-1:0] lsu_r_data_o,

    // LSU write
    input logic lsu_aw_valid_i,
    input logic [axi_mem_pkg::ADDR_W-1:0] lsu_aw_addr_i,
    input logic lsu_w_valid_i,
    input logic [axi_mem_pkg::DATA_W-1:0] lsu_w_data_i,
    input logic [axi_mem_pkg::STRB_W-1:0] lsu_w_strb_i,
    input logic lsu_b_ready_i,
    output logic lsu_aw_ready_o,
    output logic lsu_w_ready_o,
    output logic lsu_b_valid_o,
    output logic [axi_mem_pkg::RESP_W-1:0] lsu_b_resp_o
);

    axi_rd_if ifu_rd ();
    axi_rd_if lsu_rd ();
    axi_rd_if mem_rd ();
    axi_wr_if lsu_wr ();

    assign ifu_rd.ar_valid = ifu_ar_valid_i;
    assign ifu_rd.ar_addr = ifu_ar_addr_i;
    assign ifu_rd.ar_len = ifu_ar_len_i;
    assign ifu_rd.r_ready = ifu_r_ready_i;
    assign ifu_ar_ready_o = ifu_rd.ar_ready;
    assign ifu_r_valid_o = ifu_rd.r_valid;
    assign ifu_r_resp_o = ifu_rd.r_resp;
    assign ifu_r_data_o = ifu_rd.r_data;

    assign lsu_rd.ar_valid = lsu_ar_valid_i;
    assign lsu_rd.ar_addr = lsu_ar_addr_i;
    assign lsu_rd.ar_len = lsu_ar_len_i;
    assign lsu_rd.r_ready = lsu_r_ready_i;
    assign lsu_ar_ready_o = lsu_rd.ar_ready;
    assign lsu_r_valid_o = lsu_rd.r_valid;
    assign lsu_r_resp_o = lsu_rd.r_resp;
    assign lsu_r_data_o = lsu_rd.r_data;

    // Writes bypass the arbiter
    assign lsu_wr.aw_valid = lsu_aw_valid_i;
    assign lsu_wr.aw_addr = lsu_aw_addr_i;
    assign lsu_wr.w_valid = lsu_w_valid_i;
    assign lsu_wr.w_data = lsu_w_data_i;
    assign lsu_wr.w_strb = lsu_w_strb_i;
    assign lsu_wr.b_ready = lsu_b_ready_i;
    assign lsu_aw_ready_o = lsu_wr.aw_ready;
    assign lsu_w_ready_o = lsu_wr.w_ready;
    assign lsu_b_valid_o = lsu_wr.b_valid;
    assign lsu_b_resp_o = lsu_wr.b_resp;

    axi_rd_arbiter u_rd_arbiter (
        .clk   (clk),
        .rst   (rst),
        .ifu_i (ifu_rd.slave),
        .lsu_i (lsu_rd.slave),
        .mem_o (mem_rd.master)
    );

    axi_sram u_sram (
        .clk  (clk),
        .rst  (rst),
        .rd_i (mem_rd.slave),
        .wr_i (lsu_wr.slave)
    );

endmodule

//--- logic/axi_rd_arbiter.sv
`timescale 1ns/1ps

module axi_rd_arbiter (
    input logic clk,
    input logic rst,
    axi_rd_if.slave ifu_i,
    axi_rd_if.slave lsu_i,
    axi_rd_if.master mem_o
);

    axi_mem_pkg::rd_grant_e grant_q;
    axi_mem_pkg::rd_grant_e grant_d;
    logic beat_q;
    logic ifu_sel;
    logic lsu_sel;
    logic ar_xfer;
    logic r_xfer;
    logic last_beat;

    assign ifu_sel = (grant_q == axi_mem_pkg::GRANT_IFU);
    assign lsu_sel = (grant_q == axi_mem_pkg::GRANT_LSU);

    // Granted requester onto the memory channel
    assign mem_o.ar_valid = ifu_sel ? ifu_i.ar_valid : (lsu_sel ? lsu_i.ar_valid : 1'b0);
    assign mem_o.ar_addr = ifu_sel ? ifu_i.ar_addr : (lsu_sel ? lsu_i.ar_addr : '0);
    assign mem_o.ar_len = ifu_sel ? ifu_i.ar_len : (lsu_sel ? lsu_i.ar_len : 1'b0);
    assign mem_o.r_ready = ifu_sel ? ifu_i.r_ready : (lsu_sel ? lsu_i.r_ready : 1'b0);

    // Ungranted side sees a silent channel
    assign ifu_i.ar_ready = ifu_sel ? mem_o.ar_ready : 1'b0;
    assign ifu_i.r_valid = ifu_sel ? mem_o.r_valid : 1'b0;
    assign ifu_i.r_resp = ifu_sel ? mem_o.r_resp : '0;
    assign ifu_i.r_data = ifu_sel ? mem_o.r_data : '0;

    assign lsu_i.ar_ready = lsu_sel ? mem_o.ar_ready : 1'b0;
    assign lsu_i.r_valid = lsu_sel ? mem_o.r_valid : 1'b0;
    assign lsu_i.r_resp = lsu_sel ? mem_o.r_resp : '0;
    assign lsu_i.r_data = lsu_sel ? mem_o.r_data : '0;

    assign ar_xfer = mem_o.ar_valid && mem_o.ar_ready;
    assign r_xfer = mem_o.r_valid && mem_o.r_ready;
    assign last_beat = r_xfer && (beat_q == 1'b0);

    // IFU wins from idle, handoff at burst end
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            axi_mem_pkg::GRANT_NONE: begin
                if (ifu_i.ar_valid) begin
                    grant_d = axi_mem_pkg::GRANT_IFU;
                end else if (lsu_i.ar_valid) begin
                    grant_d = axi_mem_pkg::GRANT_LSU;
                end
            end
            axi_mem_pkg::GRANT_IFU: begin
                if (last_beat) begin
                    grant_d = lsu_i.ar_valid ? axi_mem_pkg::GRANT_LSU
                                             : axi_mem_pkg::GRANT_NONE;
                end
            end
            axi_mem_pkg::GRANT_LSU: begin
                if (last_beat) begin
                    grant_d = ifu_i.ar_valid ? axi_mem_pkg::GRANT_IFU
                                             : axi_mem_pkg::GRANT_NONE;
                end
            end
            default: begin
                grant_d = axi_mem_pkg::GRANT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= axi_mem_pkg::GRANT_NONE;
        end else begin
            grant_q <= grant_d;
        end
    end

    // Beats left after the current one
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= 1'b0;
        end else if (ar_xfer) begin
            beat_q <= mem_o.ar_len;
        end else if (r_xfer && beat_q) begin
            beat_q <= beat_q - 1'b1;
        end
    end

    a_grant_legal: assert property (
        @(posedge clk) disable iff (rst)
        grant_q inside {axi_mem_pkg::GRANT_NONE, axi_mem_pkg::GRANT_IFU,
                        axi_mem_pkg::GRANT_LSU}
    );

    a_no_req_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        (grant_q == axi_mem_pkg::GRANT_NONE) |-> !mem_o.ar_valid
    );

    // Grant is held for the whole burst
    a_grant_held: assert property (
        @(posedge clk) disable iff (rst)
        (grant_q != axi_mem_pkg::GRANT_NONE && !last_beat) |=> $stable(grant_q)
    );

endmodule

//--- logic/axi_rd_if.sv
`timescale 1ns/1ps

interface axi_rd_if;

    // Read address channel
    logic ar_valid;
    logic ar_ready;
    logic [axi_mem_pkg::ADDR_W-1:0] ar_addr;
    // 0 is one beat, 1 is two beats
    logic ar_len;

    // Read data channel
    logic r_valid;
    logic r_ready;
    logic [axi_mem_pkg::RESP_W-1:0] r_resp;
    logic [axi_mem_pkg::DATA_W-1:0] r_data;

    modport master (
        output ar_valid,
        output ar_addr,
        output ar_len,
        output r_ready,
        input ar_ready,
        input r_valid,
        input r_resp,
        input r_data
    );

    modport slave (
        input ar_valid,
        input ar_addr,
        input ar_len,
        input r_ready,
        output ar_ready,
        output r_valid,
        output r_resp,
        output r_data
    );

endinterface

//--- logic/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input logic clk,
    input logic rst,
    axi_rd_if.slave rd_i,
    axi_wr_if.slave wr_i
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BEAT,
        RD_BEAT2
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    function automatic logic addr_ok(input logic [axi_mem_pkg::ADDR_W-1:0] addr);
        return addr[axi_mem_pkg::ADDR_W-1:axi_mem_pkg::WORD_LSB] < axi_mem_pkg::MEM_WORDS;
    endfunction

    logic [axi_mem_pkg::DATA_W-1:0] mem [axi_mem_pkg::MEM_WORDS];

    // Read side
    rd_state_e rd_state;
    logic rd_len_q;
    logic rd_err_q;
    logic [axi_mem_pkg::ADDR_W-1:0] rd_next_addr_q;
    logic [axi_mem_pkg::DATA_W-1:0] r_data_q;
    logic [axi_mem_pkg::RESP_W-1:0] r_resp_q;
    logic ar_xfer;
    logic r_xfer;
    logic rd_second;
    logic rd_fetch;
    logic rd_fetch_ok;
    logic [axi_mem_pkg::ADDR_W-1:0] rd_fetch_addr;
    logic [axi_mem_pkg::MEM_IDX_W-1:0] rd_idx;

    // Write side
    wr_state_e wr_state;
    logic [axi_mem_pkg::ADDR_W-1:0] wr_addr_q;
    logic [axi_mem_pkg::RESP_W-1:0] b_resp_q;
    logic aw_xfer;
    logic w_xfer;
    logic b_xfer;
    logic wr_ok;
    logic [axi_mem_pkg::MEM_IDX_W-1:0] wr_idx;

    assign ar_xfer = rd_i.ar_valid && rd_i.ar_ready;
    assign r_xfer = rd_i.r_valid && rd_i.r_ready;
    assign rd_second = r_xfer && (rd_state == RD_BEAT) && rd_len_q;
    assign rd_fetch = ar_xfer || rd_second;
    assign rd_fetch_addr = ar_xfer ? rd_i.ar_addr : rd_next_addr_q;
    // Second beat inherits an error from the first
    assign rd_fetch_ok = addr_ok(rd_fetch_addr) && !(rd_second && rd_err_q);
    assign rd_idx = rd_fetch_addr[axi_mem_pkg::WORD_LSB +: axi_mem_pkg::MEM_IDX_W];

    assign rd_i.ar_ready = (rd_state == RD_IDLE);
    assign rd_i.r_valid = (rd_state != RD_IDLE);
    assign rd_i.r_data = r_data_q;
    assign rd_i.r_resp = r_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            rd_len_q <= 1'b0;
            rd_err_q <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_xfer) begin
                        rd_state <= RD_BEAT;
                        rd_len_q <= rd_i.ar_len;
                        rd_err_q <= !rd_fetch_ok;
                    end
                end
                RD_BEAT: begin
                    if (r_xfer) begin
                        rd_state <= rd_len_q ? RD_BEAT2 : RD_IDLE;
                    end
                end
                RD_BEAT2: begin
                    if (r_xfer) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // Beat data is loaded only on a fetch, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (ar_xfer) begin
            rd_next_addr_q <= rd_i.ar_addr + axi_mem_pkg::BEAT_BYTES;
        end
        if (rd_fetch) begin
            r_data_q <= rd_fetch_ok ? mem[rd_idx] : '0;
            r_resp_q <= rd_fetch_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
        end
    end

    assign aw_xfer = wr_i.aw_valid && wr_i.aw_ready;
    assign w_xfer = wr_i.w_valid && wr_i.w_ready;
    assign b_xfer = wr_i.b_valid && wr_i.b_ready;
    assign wr_ok = addr_ok(wr_addr_q);
    assign wr_idx = wr_addr_q[axi_mem_pkg::WORD_LSB +: axi_mem_pkg::MEM_IDX_W];

    assign wr_i.aw_ready = (wr_state == WR_IDLE);
    assign wr_i.w_ready = (wr_state == WR_DATA);
    assign wr_i.b_valid = (wr_state == WR_RESP);
    assign wr_i.b_resp = b_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_xfer) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_xfer) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_xfer) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_xfer) begin
            wr_addr_q <= wr_i.aw_addr;
        end
        if (w_xfer) begin
            b_resp_q <= wr_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
        end
    end

    // Strobed byte merge, skipped when out of range
    always_ff @(posedge clk) begin
        if (w_xfer && wr_ok) begin
            for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
                if (wr_i.w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_i.w_data[8*i +: 8];
                end
            end
        end
    end

    a_r_hold: assert property (
        @(posedge clk) disable iff (rst)
        (rd_i.r_valid && !rd_i.r_ready) |=>
            (rd_i.r_valid && $stable(rd_i.r_data) && $stable(rd_i.r_resp))
    );

    a_b_hold: assert property (
        @(posedge clk) disable iff (rst)
        (wr_i.b_valid && !wr_i.b_ready) |=> (wr_i.b_valid && $stable(wr_i.b_resp))
    );

endmodule

//--- logic/axi_wr_if.sv
`timescale 1ns/1ps

interface axi_wr_if;

    // Write address channel
    logic aw_valid;
    logic aw_ready;
    logic [axi_mem_pkg::ADDR_W-1:0] aw_addr;

    // Write data channel
    logic w_valid;
    logic w_ready;
    logic [axi_mem_pkg::DATA_W-1:0] w_data;
    logic [axi_mem_pkg::STRB_W-1:0] w_strb;

    // Write response channel
    logic b_valid;
    logic b_ready;
    logic [axi_mem_pkg::RESP_W-1:0] b_resp;

    modport master (
        output aw_valid,
        output aw_addr,
        output w_valid,
        output w_data,
        output w_strb,
        output b_ready,
        input aw_ready,
        input w_ready,
        input b_valid,
        input b_resp
    );

    modport slave (
        input aw_valid,
        input aw_addr,
        input w_valid,
        input w_data,
        input w_strb,
        input b_ready,
        output aw_ready,
        output w_ready,
        output b_valid,
        output b_resp
    );

endinterface

//--- verif/axi_mem_subsys_tb.sv
`timescale 1ns/1ps

module axi_mem_subsys_tb;

    localparam int TIMEOUT = 200;
    localparam logic [31:0] MEM_BYTES = axi_mem_pkg::MEM_WORDS * axi_mem_pkg::STRB_W;
    // IFU r_valid, LSU r_valid, IFU ar_ready, LSU ar_ready, aw_ready, w_ready, b_valid
    localparam logic [6:0] RESET_OUTS = 7'b0000100;

    logic clk = 1'b0;
    logic rst;

    // Read requesters, index 0 is the IFU and index 1 the LSU
    logic rd_ar_valid [2];
    logic [axi_mem_pkg::ADDR_W-1:0] rd_ar_addr [2];
    logic rd_ar_len [2];
    logic rd_r_ready [2];
    wire rd_ar_ready [2];
    wire rd_r_valid [2];
    wire [axi_mem_pkg::RESP_W-1:0] rd_r_resp [2];
    wire [axi_mem_pkg::DATA_W-1:0] rd_r_data [2];

    logic aw_valid;
    logic [axi_mem_pkg::ADDR_W-1:0] aw_addr;
    logic w_valid;
    logic [axi_mem_pkg::DATA_W-1:0] w_data;
    logic [axi_mem_pkg::STRB_W-1:0] w_strb;
    logic b_ready;
    wire aw_ready;
    wire w_ready;
    wire b_valid;
    wire [axi_mem_pkg::RESP_W-1:0] b_resp;

    wire [6:0] reset_outs = {rd_r_valid[0], rd_r_valid[1], rd_ar_ready[0], rd_ar_ready[1],
                             aw_ready, w_ready, b_valid};

    // Reference model and expectations
    logic [axi_mem_pkg::DATA_W-1:0] model [axi_mem_pkg::MEM_WORDS];
    logic [axi_mem_pkg::DATA_W-1:0] exp_data [2];
    logic [axi_mem_pkg::RESP_W-1:0] exp_resp [2];
    int beats_left [2];
    logic rd_active [2];
    logic [axi_mem_pkg::RESP_W-1:0] exp_b_resp;
    logic both_test;
    string test_name;
    int errors = 0;
    int passed = 0;
    int mark_errors = 0;
    logic [31:0] seed;

    always #20 clk = ~clk;

    axi_mem_subsys i_dut (
        .clk            (clk),
        .rst            (rst),
        .ifu_ar_valid_i (rd_ar_valid[0]),
        .ifu_ar_addr_i  (rd_ar_addr[0]),
        .ifu_ar_len_i   (rd_ar_len[0]),
        .ifu_r_ready_i  (rd_r_ready[0]),
        .ifu_ar_ready_o (rd_ar_ready[0]),
        .ifu_r_valid_o  (rd_r_valid[0]),
        .ifu_r_resp_o   (rd_r_resp[0]),
        .ifu_r_data_o   (rd_r_data[0]),
        .lsu_ar_valid_i (rd_ar_valid[1]),
        .lsu_ar_addr_i  (rd_ar_addr[1]),
        .lsu_ar_len_i   (rd_ar_len[1]),
        .lsu_r_ready_i  (rd_r_ready[1]),
        .lsu_ar_ready_o (rd_ar_ready[1]),
        .lsu_r_valid_o  (rd_r_valid[1]),
        .lsu_r_resp_o   (rd_r_resp[1]),
        .lsu_r_data_o   (rd_r_data[1]),
        .lsu_aw_valid_i (aw_valid),
        .lsu_aw_addr_i  (aw_addr),
        .lsu_w_valid_i  (w_valid),
        .lsu_w_data_i   (w_data),
        .lsu_w_strb_i   (w_strb),
        .lsu_b_ready_i  (b_ready),
        .lsu_aw_ready_o (aw_ready),
        .lsu_w_ready_o  (w_ready),
        .lsu_b_valid_o  (b_valid),
        .lsu_b_resp_o   (b_resp)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic coin();
        logic [31:0] v;
        v = lcg_next();
        return v[17];
    endfunction

    function automatic logic [axi_mem_pkg::DATA_W-1:0] model_word(input logic [31:0] addr);
        return (addr < MEM_BYTES) ? model[addr >> axi_mem_pkg::WORD_LSB] : '0;
    endfunction

    function automatic logic [axi_mem_pkg::RESP_W-1:0] model_resp(input logic [31:0] addr);
        return (addr < MEM_BYTES) ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
    endfunction

    a_reset: assert property (@(posedge clk) $fell(rst) |-> (reset_outs === RESET_OUTS))
    else begin
        $display("[ERROR] %s: expected reset outputs %b, actual %b",
                 test_name, RESET_OUTS, $sampled(reset_outs));
        errors++;
    end

    for (genvar g = 0; g < 2; g++) begin : g_rd_chk
        a_beat_data: assert property (@(posedge clk) disable iff (rst)
            (rd_r_valid[g] && rd_r_ready[g]) |->
                (rd_r_data[g] === exp_data[g] && rd_r_resp[g] === exp_resp[g]))
        else begin
            $display("[ERROR] %s: port %0d expected data %h resp %0d, actual data %h resp %0d",
                     test_name, g, $sampled(exp_data[g]), $sampled(exp_resp[g]),
                     $sampled(rd_r_data[g]), $sampled(rd_r_resp[g]));
            errors++;
        end

        a_owner: assert property (@(posedge clk) disable iff (rst)
            rd_r_valid[g] |-> rd_active[g])
        else begin
            $display("%s: r_valid reached port %0d with no read outstanding", test_name, g);
            errors++;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(rd_r_valid[0] && rd_r_valid[1]))
    else begin
        $display("%s: r_valid reached the IFU and the LSU at once", test_name);
        errors++;
    end

    // Same-cycle requests, IFU must finish first
    a_ifu_first: assert property (@(posedge clk) disable iff (rst)
        (both_test && rd_r_valid[1]) |-> !rd_active[0])
    else begin
        $display("%s: LSU was served while the IFU read was still open", test_name);
        errors++;
    end

    a_b_resp: assert property (@(posedge clk) disable iff (rst)
        (b_valid && b_ready) |-> (b_resp == exp_b_resp))
    else begin
        $display("[ERROR] %s: expected b_resp %0d, actual b_resp %0d",
                 test_name, $sampled(exp_b_resp), $sampled(b_resp));
        errors++;
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_resp)))
    else begin
        $display("%s: b_valid or b_resp changed before b_ready", test_name);
        errors++;
    end

    task automatic issue_read(input int r, input logic [31:0] addr, input logic len,
                              input bit stall);
        int idle;
        logic ar_done;
        logic r_done;
        idle = 0;
        exp_data[r] = model_word(addr);
        exp_resp[r] = model_resp(addr);
        beats_left[r] = len ? 2 : 1;
        rd_active[r] = 1'b1;
        rd_ar_valid[r] = 1'b1;
        rd_ar_addr[r] = addr;
        rd_ar_len[r] = len;
        rd_r_ready[r] = stall ? coin() : 1'b1;
        while (beats_left[r] != 0 && idle < TIMEOUT) begin
            @(negedge clk);
            ar_done = rd_ar_valid[r] && rd_ar_ready[r];
            r_done = rd_r_valid[r] && rd_r_ready[r];
            @(posedge clk);
            #1;
            if (ar_done) begin
                rd_ar_valid[r] = 1'b0;
            end
            if (r_done) begin
                beats_left[r]--;
                addr = addr + axi_mem_pkg::STRB_W;
                exp_data[r] = model_word(addr);
                exp_resp[r] = model_resp(addr);
                idle = 0;
            end else begin
                idle++;
            end
            rd_r_ready[r] = stall ? coin() : 1'b1;
        end
        if (beats_left[r] != 0) begin
            $display("%s: read on port %0d timed out waiting for its beats", test_name, r);
            errors++;
            beats_left[r] = 0;
        end
        rd_ar_valid[r] = 1'b0;
        rd_r_ready[r] = 1'b0;
        rd_active[r] = 1'b0;
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input int hold);
        int idle;
        logic aw_done;
        logic w_done;
        logic b_done;
        logic finished;
        idle = 0;
        finished = 1'b0;
        exp_b_resp = model_resp(addr);
        aw_valid = 1'b1;
        aw_addr = addr;
        w_valid = 1'b1;
        w_data = data;
        w_strb = strb;
        b_ready = (hold == 0);
        while (!finished && idle < TIMEOUT) begin
            @(negedge clk);
            aw_done = aw_valid && aw_ready;
            w_done = w_valid && w_ready;
            b_done = b_valid && b_ready;
            if (b_valid && hold > 0) begin
                hold--;
            end
            @(posedge clk);
            #1;
            if (aw_done) begin
                aw_valid = 1'b0;
            end
            if (w_done) begin
                w_valid = 1'b0;
            end
            finished = b_done;
            b_ready = (hold == 0) && !b_done;
            idle = (aw_done || w_done || b_done) ? 0 : idle + 1;
        end
        if (!finished) begin
            $display("%s: write to %h timed out waiting for its response", test_name, addr);
            errors++;
        end else if (addr < MEM_BYTES) begin
            for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
                if (strb[i]) begin
                    model[addr >> axi_mem_pkg::WORD_LSB][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
        aw_valid = 1'b0;
        w_valid = 1'b0;
        b_ready = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        mark_errors = errors;
    endtask

    task automatic end_test();
        if (errors == mark_errors) begin
            passed++;
        end
        $display("Test %s finished with %0d errors", test_name, errors - mark_errors);
    endtask

    initial begin
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0] strb;
        for (int r = 0; r < 2; r++) begin
            rd_ar_valid[r] = 1'b0;
            rd_ar_addr[r] = '0;
            rd_ar_len[r] = 1'b0;
            rd_r_ready[r] = 1'b0;
            beats_left[r] = 0;
            rd_active[r] = 1'b0;
            exp_data[r] = '0;
            exp_resp[r] = '0;
        end
        aw_valid = 1'b0;
        aw_addr = '0;
        w_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        b_ready = 1'b0;
        exp_b_resp = '0;
        both_test = 1'b0;
        seed = 32'h4d9b_9a44;
        rst = 1'b1;
        start_test("reset_state");
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        end_test();

        start_test("write_readback");
        for (int i = 0; i < 32; i++) begin
            lsu_write(i * 8, {lcg_next(), lcg_next()}, 8'hff, 0);
        end
        for (int i = 0; i < 8; i++) begin
            addr = ((lcg_next() >> 16) % 32) << 3;
            data = {lcg_next(), lcg_next()};
            strb = 8'(lcg_next() >> 12);
            lsu_write(addr, data, strb, 0);
            issue_read(1, addr, 1'b0, 1'b0);
        end
        end_test();

        start_test("ifu_burst");
        issue_read(0, 32'h40, 1'b1, 1'b0);
        end_test();

        start_test("simultaneous");
        both_test = 1'b1;
        fork
            issue_read(0, 32'h10, 1'b1, 1'b0);
            issue_read(1, 32'h80, 1'b1, 1'b0);
        join
        both_test = 1'b0;
        end_test();

        start_test("read_stall");
        for (int i = 0; i < 6; i++) begin
            addr = ((lcg_next() >> 16) % 31) << 3;
            issue_read(i % 2, addr, 1'b1, 1'b1);
        end
        end_test();

        start_test("out_of_range");
        lsu_write(32'h1000, {lcg_next(), lcg_next()}, 8'hff, 0);
        issue_read(1, 32'h0, 1'b0, 1'b0);
        issue_read(1, 32'h7f8, 1'b1, 1'b0);
        issue_read(0, 32'h1000, 1'b1, 1'b1);
        end_test();

        start_test("write_stall");
        lsu_write(32'h30, {lcg_next(), lcg_next()}, 8'(lcg_next() >> 12), 5);
        data = {lcg_next(), lcg_next()};
        fork
            lsu_write(32'h48, data, 8'h0f, 3);
            issue_read(0, 32'h60, 1'b1, 1'b1);
        join
        issue_read(1, 32'h30, 1'b0, 1'b0);
        issue_read(1, 32'h48, 1'b0, 1'b0);
        end_test();

        $display("Tests passed: %0d, errors: %0d", passed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
